//--- rtl/bus_pkg.sv
package bus_pkg;

	// --------------------
	// bus widths
	// --------------------
	localparam int TID_W  = 8;
	localparam int DATA_W = 128;
	localparam int SEL_W  = DATA_W / 8;
	localparam int ADDR_W = 32;

	// --------------------
	// request from the cpu
	// --------------------
	// one request per strobe cycle, no burst
	typedef struct packed {
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [TID_W-1:0]  tid;
		logic [ADDR_W-1:0] padr;
		logic [DATA_W-1:0] data;
	} fab_req_t;

	// --------------------
	// response to the cpu
	// --------------------
	// ack for one cycle per request
	// tid copied back so answers may return out of order
	typedef struct packed {
		logic              ack;
		logic              err;
		logic [TID_W-1:0]  tid;
		logic [DATA_W-1:0] dat;
	} fab_resp_t;

endpackage

//--- rtl/soc_map_pkg.sv
package soc_map_pkg;

	// --------------------
	// address views
	// --------------------
	// io space, 4k devices of 256 bytes in one 1M region
	typedef struct packed {
		logic [11:0] region;
		logic [11:0] device;
		logic [7:0]  offset;
	} io_addr_t;

	// memory space, 16M banks
	typedef struct packed {
		logic [7:0]  bank;
		logic [23:0] index;
	} mem_addr_t;

	typedef union packed {
		io_addr_t  io;
		mem_addr_t mem;
	} phys_addr_u;

	// --------------------
	// address map
	// --------------------
	localparam logic [11:0] IO_REGION  = 12'hFD0;
	localparam logic [11:0] LED_DEV    = 12'hFFF;
	localparam logic [11:0] RSTCTL_DEV = 12'hFFC;
	localparam logic [7:0]  SCR_BANK   = 8'hFF;

	// scratchpad, 16-byte words, aliases across its bank
	localparam int SCR_DEPTH = 256;
	localparam int SCR_AW    = $clog2(SCR_DEPTH);
	localparam int SCR_LSB   = 4;

	// reset control
	localparam int          RST_PULSE   = 64;
	localparam int          RST_CNT_W   = $clog2(RST_PULSE + 1);
	localparam logic [2:0]  CLKEN_RESET = 3'b110;

	// periodic tick
	localparam int TICK_PERIOD = 1000;
	localparam int TICK_CNT_W  = $clog2(TICK_PERIOD);
	localparam int TICK_ON     = 150;
	localparam int TICK_OFF    = 200;

	// answer to an unmapped access
	localparam logic [bus_pkg::DATA_W-1:0] ERR_DATA = '1;

endpackage

//--- rtl/addr_router.sv
`timescale 1ns/100ps

module addr_router (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_req_t   req_i,
	output bus_pkg::fab_req_t   scr_req_o,
	output bus_pkg::fab_req_t   led_req_o,
	output bus_pkg::fab_req_t   rst_req_o,
	output bus_pkg::fab_resp_t  err_resp_o
);
	import bus_pkg::*;
	import soc_map_pkg::*;

	phys_addr_u pa;
	logic       io_hit;
	logic       scr_sel;
	logic       led_sel;
	logic       rst_sel;
	logic       err_sel;

	assign pa = req_i.padr;

	// io region first, then device inside it
	assign io_hit  = (pa.io.region == IO_REGION);
	assign led_sel = req_i.stb & io_hit & (pa.io.device == LED_DEV);
	assign rst_sel = req_i.stb & io_hit & (pa.io.device == RSTCTL_DEV);
	// whole bank maps onto the scratchpad
	assign scr_sel = req_i.stb & (pa.mem.bank == SCR_BANK);
	// nobody claims it
	assign err_sel = req_i.stb & ~(scr_sel | led_sel | rst_sel);

	// --------------------
	// request copies
	// --------------------
	always_comb begin
		scr_req_o     = req_i;
		scr_req_o.stb = scr_sel;
		led_req_o     = req_i;
		led_req_o.stb = led_sel;
		rst_req_o     = req_i;
		rst_req_o.stb = rst_sel;
	end

	// --------------------
	// unmapped answer
	// --------------------
	// all ones data with the latency of the one-cycle targets
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			err_resp_o <= '0;
		end else begin
			err_resp_o.ack <= err_sel;
			err_resp_o.err <= 1'b1;
			err_resp_o.tid <= req_i.tid;
			err_resp_o.dat <= ERR_DATA;
		end
	end

	// one target per strobe or the request would answer twice
	a_one_target: assert property (
		@(posedge node_clk) disable iff (rst)
		$onehot0({scr_sel, led_sel, rst_sel})
	);

endmodule

//--- rtl/scratch_ram.sv
`timescale 1ns/100ps

module scratch_ram (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_req_t   req_i,
	output bus_pkg::fab_resp_t  resp_o
);
	import bus_pkg::*;
	import soc_map_pkg::*;

	logic [DATA_W-1:0] mem [SCR_DEPTH];

	phys_addr_u        pa;
	logic [SCR_AW-1:0] idx;

	// stage 1 state
	logic              s1_vld;
	logic              s1_we;
	logic [TID_W-1:0]  s1_tid;
	logic [DATA_W-1:0] rd_q;

	assign pa  = req_i.padr;
	// word index, upper bank bits ignored
	assign idx = pa.mem.index[SCR_LSB +: SCR_AW];

	// --------------------
	// stage 1
	// --------------------
	// byte lane writes, read word latched for stage 2
	always_ff @(posedge node_clk) begin
		if (req_i.stb && req_i.we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b])
					mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
			end
		end
		if (req_i.stb && !req_i.we)
			rd_q <= mem[idx];
		s1_tid <= req_i.tid;
	end

	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			s1_vld <= 1'b0;
			s1_we  <= 1'b0;
		end else begin
			s1_vld <= req_i.stb;
			s1_we  <= req_i.we;
		end
	end

	// --------------------
	// stage 2
	// --------------------
	// writes answer with zero data
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			resp_o <= '0;
		end else begin
			resp_o.ack <= s1_vld;
			resp_o.err <= 1'b0;
			resp_o.tid <= s1_tid;
			resp_o.dat <= s1_we ? '0 : rd_q;
		end
	end

endmodule

//--- rtl/led_port.sv
`timescale 1ns/100ps

module led_port (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_req_t   req_i,
	output bus_pkg::fab_resp_t  resp_o,
	output logic [7:0]          led_o
);
	import bus_pkg::*;

	// byte 0 only, other lanes ignored
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst)
			led_o <= '0;
		else if (req_i.stb && req_i.we && req_i.sel[0])
			led_o <= req_i.data[7:0];
	end

	// read returns the value before any write of this cycle
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			resp_o <= '0;
		end else begin
			resp_o.ack <= req_i.stb;
			resp_o.err <= 1'b0;
			resp_o.tid <= req_i.tid;
			resp_o.dat <= req_i.we ? '0 : DATA_W'(led_o);
		end
	end

endmodule

//--- rtl/reset_ctrl.sv
`timescale 1ns/100ps

module reset_ctrl (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_req_t   req_i,
	output bus_pkg::fab_resp_t  resp_o,
	output logic [15:0]         periph_rst_o,
	output logic [2:0]          clken_o
);
	import bus_pkg::*;
	import soc_map_pkg::*;

	logic [15:0]          mask_q;
	logic [RST_CNT_W-1:0] cnt_q;
	logic                 wr_mask;
	logic                 wr_clken;
	logic [DATA_W-1:0]    rd_dat;

	// lanes 1:0 hit the mask, lanes 3:2 the clock enables
	assign wr_mask  = req_i.stb & req_i.we & (|req_i.sel[1:0]);
	assign wr_clken = req_i.stb & req_i.we & (|req_i.sel[3:2]);

	// --------------------
	// pulse counter
	// --------------------
	// parks at RST_PULSE, restarts on every mask write
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			mask_q  <= '0;
			cnt_q   <= RST_CNT_W'(RST_PULSE);
			clken_o <= CLKEN_RESET;
		end else begin
			if (wr_mask) begin
				mask_q <= req_i.data[15:0];
				cnt_q  <= '0;
			end else if (cnt_q != RST_CNT_W'(RST_PULSE)) begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (wr_clken)
				clken_o <= req_i.data[18:16];
		end
	end

	// mask visible only while the pulse runs
	assign periph_rst_o = (cnt_q < RST_CNT_W'(RST_PULSE)) ? mask_q : '0;

	// readback, clock enables in bits 18:16
	always_comb begin
		rd_dat        = '0;
		rd_dat[18:16] = clken_o;
	end

	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			resp_o <= '0;
		end else begin
			resp_o.ack <= req_i.stb;
			resp_o.err <= 1'b0;
			resp_o.tid <= req_i.tid;
			resp_o.dat <= req_i.we ? '0 : rd_dat;
		end
	end

	a_cnt_range: assert property (
		@(posedge node_clk) disable iff (rst)
		cnt_q <= RST_CNT_W'(RST_PULSE)
	);

endmodule

//--- rtl/tick_timer.sv
`timescale 1ns/100ps

module tick_timer (
	input  logic node_clk,
	input  logic rst,
	output logic tmr_irq_o
);
	import soc_map_pkg::*;

	logic [TICK_CNT_W-1:0] cnt_q;

	// free running, modulo the period
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst)
			cnt_q <= '0;
		else if (cnt_q == TICK_CNT_W'(TICK_PERIOD - 1))
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1;
	end

	// high window inside each period
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst)
			tmr_irq_o <= 1'b0;
		else if (cnt_q == TICK_CNT_W'(TICK_ON))
			tmr_irq_o <= 1'b1;
		else if (cnt_q == TICK_CNT_W'(TICK_OFF))
			tmr_irq_o <= 1'b0;
	end

endmodule

//--- rtl/resp_merge.sv
`timescale 1ns/100ps

module resp_merge (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_resp_t  scr_resp_i,
	input  bus_pkg::fab_resp_t  led_resp_i,
	input  bus_pkg::fab_resp_t  rst_resp_i,
	input  bus_pkg::fab_resp_t  err_resp_i,
	output bus_pkg::fab_resp_t  resp_o
);
	import bus_pkg::*;

	fab_resp_t  oth;
	fab_resp_t  lst [4];
	fab_resp_t  hold_q [2];
	logic [1:0] cnt_q;
	logic [2:0] n;

	// single-cycle targets, at most one of them valid
	always_comb begin
		if (led_resp_i.ack)
			oth = led_resp_i;
		else if (rst_resp_i.ack)
			oth = rst_resp_i;
		else
			oth = err_resp_i;
	end

	// --------------------
	// ordering
	// --------------------
	// held entries, then scratchpad, then the rest
	// slot 0 leaves, slots 1 and 2 wait
	always_comb begin
		lst = '{default: '0};
		n   = '0;
		if (cnt_q != 2'd0) begin
			lst[n[1:0]] = hold_q[0];
			n = n + 3'd1;
		end
		if (cnt_q == 2'd2) begin
			lst[n[1:0]] = hold_q[1];
			n = n + 3'd1;
		end
		if (scr_resp_i.ack) begin
			lst[n[1:0]] = scr_resp_i;
			n = n + 3'd1;
		end
		if (oth.ack) begin
			lst[n[1:0]] = oth;
			n = n + 3'd1;
		end
	end

	// --------------------
	// output and buffer
	// --------------------
	always_ff @(posedge node_clk or posedge rst) begin
		if (rst) begin
			resp_o <= '0;
			cnt_q  <= '0;
		end else begin
			resp_o <= lst[0];
			cnt_q  <= (n > 3'd1) ? 2'(n - 3'd1) : 2'd0;
		end
	end

	// holding entries, only read below cnt_q
	always_ff @(posedge node_clk) begin
		hold_q[0] <= lst[1];
		hold_q[1] <= lst[2];
	end

	// one request per cycle upstream keeps the one-cycle targets apart
	a_one_short: assert property (
		@(posedge node_clk) disable iff (rst)
		$onehot0({led_resp_i.ack, rst_resp_i.ack, err_resp_i.ack})
	);

	// never more than two waiting after the output slot
	a_no_overflow: assert property (
		@(posedge node_clk) disable iff (rst)
		n <= 3'd3
	);

endmodule

//--- rtl/soc_fabric_top.sv
`timescale 1ns/100ps

module soc_fabric_top (
	input  logic                node_clk,
	input  logic                rst,
	input  bus_pkg::fab_req_t   req_i,
	output bus_pkg::fab_resp_t  resp_o,
	output logic [7:0]          led_o,
	output logic [15:0]         periph_rst_o,
	output logic [2:0]          clken_o,
	output logic                tmr_irq_o
);
	import bus_pkg::*;

	// per target request copies
	fab_req_t  scr_req;
	fab_req_t  led_req;
	fab_req_t  rst_req;

	// target answers into the merge
	fab_resp_t scr_resp;
	fab_resp_t led_resp;
	fab_resp_t rst_resp;
	fab_resp_t err_resp;

	// --------------------
	// decode
	// --------------------
	addr_router u_router (
		.node_clk   (node_clk),
		.rst        (rst),
		.req_i      (req_i),
		.scr_req_o  (scr_req),
		.led_req_o  (led_req),
		.rst_req_o  (rst_req),
		.err_resp_o (err_resp)
	);

	// --------------------
	// targets
	// --------------------
	scratch_ram u_scr (
		.node_clk (node_clk),
		.rst      (rst),
		.req_i    (scr_req),
		.resp_o   (scr_resp)
	);

	led_port u_led (
		.node_clk (node_clk),
		.rst      (rst),
		.req_i    (led_req),
		.resp_o   (led_resp),
		.led_o    (led_o)
	);

	reset_ctrl u_rstctl (
		.node_clk     (node_clk),
		.rst          (rst),
		.req_i        (rst_req),
		.resp_o       (rst_resp),
		.periph_rst_o (periph_rst_o),
		.clken_o      (clken_o)
	);

	tick_timer u_tick (
		.node_clk  (node_clk),
		.rst       (rst),
		.tmr_irq_o (tmr_irq_o)
	);

	// --------------------
	// response path
	// --------------------
	resp_merge u_merge (
		.node_clk   (node_clk),
		.rst        (rst),
		.scr_resp_i (scr_resp),
		.led_resp_i (led_resp),
		.rst_resp_i (rst_resp),
		.err_resp_i (err_resp),
		.resp_o     (resp_o)
	);

endmodule

//--- tb/fabric_model.svh
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// --------------------
// model state
// --------------------
// scratchpad words, filled by the first test before any read
logic [DATA_W-1:0] m_mem [SCR_DEPTH];
logic [7:0]        m_led;
logic [2:0]        m_clken;
logic [15:0]       m_mask;

// target codes of the address map
localparam int TGT_SCR = 0;
localparam int TGT_LED = 1;
localparam int TGT_RST = 2;
localparam int TGT_ERR = 3;

// values right after reset
task automatic model_reset();
	m_led   = 8'h00;
	m_clken = CLKEN_RESET;
	m_mask  = 16'h0000;
endtask

// bank in 31:24, io region 31:20, io device 19:8
function automatic int target_of(input logic [ADDR_W-1:0] a);
	if (a[31:24] == SCR_BANK)
		return TGT_SCR;
	if (a[31:20] == IO_REGION && a[19:8] == LED_DEV)
		return TGT_LED;
	if (a[31:20] == IO_REGION && a[19:8] == RSTCTL_DEV)
		return TGT_RST;
	return TGT_ERR;
endfunction

// --------------------
// one access
// --------------------
// applies the request in issue order and returns the expected answer
function automatic fab_resp_t model_access(input fab_req_t r);
	fab_resp_t  e;
	logic [7:0] w;
	e.ack = 1'b1;
	e.err = 1'b0;
	e.tid = r.tid;
	e.dat = '0;
	// word index from bits 11:4, upper bank bits alias
	w = r.padr[11:4];
	case (target_of(r.padr))
		TGT_SCR: begin
			if (r.we) begin
				for (int b = 0; b < SEL_W; b++)
					if (r.sel[b])
						m_mem[w][b*8 +: 8] = r.data[b*8 +: 8];
			end else begin
				e.dat = m_mem[w];
			end
		end
		TGT_LED: begin
			if (!r.we)
				e.dat = DATA_W'(m_led);
			else if (r.sel[0])
				m_led = r.data[7:0];
		end
		TGT_RST: begin
			if (r.we) begin
				if (|r.sel[1:0])
					m_mask = r.data[15:0];
				if (|r.sel[3:2])
					m_clken = r.data[18:16];
			end else begin
				e.dat[18:16] = m_clken;
			end
		end
		default: begin
			// unmapped, all ones whatever the direction
			e.err = 1'b1;
			e.dat = '1;
		end
	endcase
	return e;
endfunction

`endif

//--- tb/soc_fabric_tb.sv
`timescale 1ns/100ps

module soc_fabric_tb;
	import bus_pkg::*;
	import soc_map_pkg::*;

	// --------------------
	// run lengths
	// --------------------
	localparam int N_SCR     = 300;
	localparam int N_LED     = 100;
	localparam int N_ERR     = 100;
	localparam int N_MIX     = 300;
	localparam int MAX_LAT   = 4;
	localparam int DRAIN_CYC = 8;
	localparam int LEN_SCR   = SCR_DEPTH + N_SCR + DRAIN_CYC + 1;
	localparam int LEN_LED   = 2 * N_LED + DRAIN_CYC + 2;
	localparam int LEN_ERR   = N_ERR + DRAIN_CYC + 1;
	localparam int LEN_MIX   = N_MIX + DRAIN_CYC + 1;
	localparam int LEN_RST   = 2 * RST_PULSE + 20 + DRAIN_CYC;
	localparam int LEN_TMR   = 2 * TICK_PERIOD + TICK_OFF + 2;
	// twice the summed test lengths plus reset
	localparam int TIMEOUT_CYC =
		2 * (8 + LEN_SCR + LEN_LED + LEN_ERR + LEN_MIX + LEN_RST + LEN_TMR);

	logic        node_clk;
	logic        rst;
	fab_req_t    req;
	fab_resp_t   resp;
	logic [7:0]  led;
	logic [15:0] periph_rst;
	logic [2:0]  clken;
	logic        tmr_irq;

	// bookkeeping
	int               cyc = 0;
	int               errors = 0;
	int               n_checks = 0;
	int               n_tests = 0;
	int               n_bad = 0;
	int               err_at_start = 0;
	logic [15:0]      lfsr = 16'd13239;
	logic [TID_W-1:0] next_tid = '0;
	logic [2:0]       clken_at_rst;
	logic [15:0]      prst_at_rst;

	// expected answer and issue cycle per tid in flight
	fab_resp_t pend_exp [int];
	int        pend_cyc [int];

	`include "fabric_model.svh"

	soc_fabric_top i_dut (
		.node_clk     (node_clk),
		.rst          (rst),
		.req_i        (req),
		.resp_o       (resp),
		.led_o        (led),
		.periph_rst_o (periph_rst),
		.clken_o      (clken),
		.tmr_irq_o    (tmr_irq)
	);

	// --------------------
	// clock and watchdog
	// --------------------
	initial begin
		node_clk = 1'b0;
		forever #50 node_clk = ~node_clk;
	end

	always @(posedge node_clk)
		cyc <= cyc + 1;

	initial begin
		while (cyc < TIMEOUT_CYC)
			@(posedge node_clk);
		$display("run stopped by timeout after %0d cycles", cyc);
		$display("tests failed");
		$finish;
	end

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_resp(input fab_resp_t got, input fab_resp_t want);
		n_checks++;
		if (got.err !== want.err) begin
			$display("ERROR resp_o.err tid 0x%h: got 0x%h exp 0x%h", got.tid, got.err, want.err);
			errors++;
		end
		if (got.dat !== want.dat) begin
			$display("ERROR resp_o.dat tid 0x%h: got 0x%h exp 0x%h", got.tid, got.dat, want.dat);
			errors++;
		end
	endtask

	task automatic check_led(input logic [7:0] got, input logic [7:0] want);
		n_checks++;
		if (got !== want) begin
			$display("ERROR led_o: got 0x%h exp 0x%h", got, want);
			errors++;
		end
	endtask

	task automatic check_rst(input logic [15:0] got, input logic [15:0] want);
		n_checks++;
		if (got !== want) begin
			$display("ERROR periph_rst_o: got 0x%h exp 0x%h", got, want);
			errors++;
		end
	endtask

	task automatic check_clken(input logic [2:0] got, input logic [2:0] want);
		n_checks++;
		if (got !== want) begin
			$display("ERROR clken_o: got 0x%h exp 0x%h", got, want);
			errors++;
		end
	endtask

	// --------------------
	// response monitor
	// --------------------
	// sampled at the falling edge and matched by tid
	always @(negedge node_clk) begin
		int lat;
		if (!rst && resp.ack) begin
			if (!pend_exp.exists(int'(resp.tid))) begin
				$display("response for tid 0x%h that is not pending", resp.tid);
				errors++;
			end else begin
				lat = cyc - pend_cyc[int'(resp.tid)] - 1;
				check_resp(resp, pend_exp[int'(resp.tid)]);
				if (lat > MAX_LAT) begin
					$display("tid 0x%h answered after %0d cycles", resp.tid, lat);
					errors++;
				end
				pend_exp.delete(int'(resp.tid));
				pend_cyc.delete(int'(resp.tid));
			end
		end
	end

	// --------------------
	// stimulus helpers
	// --------------------
	// fibonacci lfsr with taps 16 14 13 11 stepped once per bit
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[126:0], lfsr[15]};
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
		return r;
	endfunction

	function automatic logic [ADDR_W-1:0] scr_addr();
		return {SCR_BANK, 24'(rand_bits(24))};
	endfunction

	function automatic logic [ADDR_W-1:0] led_addr();
		return {IO_REGION, LED_DEV, 8'(rand_bits(8))};
	endfunction

	function automatic logic [ADDR_W-1:0] rstc_addr();
		return {IO_REGION, RSTCTL_DEV, 8'(rand_bits(8))};
	endfunction

	// half land in the io region on an absent device
	function automatic logic [ADDR_W-1:0] unmapped_addr();
		logic [ADDR_W-1:0] a;
		a = ADDR_W'(rand_bits(ADDR_W));
		if (1'(rand_bits(1)))
			a[31:20] = IO_REGION;
		while (target_of(a) != TGT_ERR)
			a = ADDR_W'(rand_bits(ADDR_W));
		return a;
	endfunction

	task automatic draw_fields(output logic we, output logic [SEL_W-1:0] sel,
			output logic [DATA_W-1:0] d);
		we  = 1'(rand_bits(1));
		sel = SEL_W'(rand_bits(SEL_W));
		d   = rand_bits(DATA_W);
	endtask

	// one request on the next edge with its expectation booked at issue
	task automatic send(input logic we, input logic [SEL_W-1:0] sel,
			input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		fab_req_t r;
		r.stb  = 1'b1;
		r.we   = we;
		r.sel  = sel;
		r.tid  = next_tid;
		r.padr = a;
		r.data = d;
		@(posedge node_clk);
		if (pend_exp.exists(int'(next_tid))) begin
			$display("tid 0x%h reused while still pending", next_tid);
			errors++;
		end
		pend_exp[int'(next_tid)] = model_access(r);
		pend_cyc[int'(next_tid)] = cyc;
		req <= r;
		next_tid = next_tid + 1'b1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge node_clk);
			req.stb <= 1'b0;
		end
	endtask

	// wait out the last answers and report the ones that never came
	task automatic drain();
		int waited;
		idle(1);
		waited = 0;
		while (pend_exp.num() != 0 && waited < DRAIN_CYC) begin
			@(negedge node_clk);
			waited++;
		end
		if (pend_exp.num() != 0) begin
			foreach (pend_exp[t]) begin
				$display("no response for tid 0x%h", 8'(t));
				errors++;
			end
			pend_exp.delete();
			pend_cyc.delete();
		end
	endtask

	task automatic start_test();
		err_at_start = errors;
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		if (errors != err_at_start)
			n_bad++;
		$display("test %0d %s: %0d errors", n_tests, name, errors - err_at_start);
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic test_scratch();
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		start_test();
		// every word once with random alias bits around the index
		for (int i = 0; i < SCR_DEPTH; i++) begin
			a       = scr_addr();
			a[11:4] = 8'(i);
			d       = rand_bits(DATA_W);
			send(1'b1, '1, a, d);
		end
		for (int i = 0; i < N_SCR; i++) begin
			draw_fields(we, sel, d);
			a = scr_addr();
			send(we, sel, a, d);
		end
		drain();
		finish_test("scratchpad");
	endtask

	task automatic test_led();
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		start_test();
		check_led(led, m_led);
		for (int i = 0; i < N_LED; i++) begin
			draw_fields(we, sel, d);
			a = led_addr();
			send(we, sel, a, d);
			idle(1);
			@(negedge node_clk);
			check_led(led, m_led);
		end
		drain();
		finish_test("led port");
	endtask

	task automatic test_unmapped();
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		start_test();
		for (int i = 0; i < N_ERR; i++) begin
			draw_fields(we, sel, d);
			a = unmapped_addr();
			send(we, sel, a, d);
		end
		drain();
		finish_test("unmapped");
	endtask

	// back to back traffic that makes the merge collide
	task automatic test_mixed();
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		start_test();
		for (int i = 0; i < N_MIX; i++) begin
			draw_fields(we, sel, d);
			case (2'(rand_bits(2)))
				2'd0:    a = scr_addr();
				2'd1:    a = led_addr();
				2'd2:    a = rstc_addr();
				default: a = unmapped_addr();
			endcase
			send(we, sel, a, d);
		end
		drain();
		finish_test("mixed traffic");
	endtask

	task automatic test_reset_ctrl();
		logic [15:0] mask;
		logic [2:0]  val;
		int          high;
		start_test();
		check_clken(clken_at_rst, CLKEN_RESET);
		check_rst(prst_at_rst, 16'h0000);
		// let pulses from earlier writes run out
		idle(RST_PULSE + 2);
		@(negedge node_clk);
		check_rst(periph_rst, 16'h0000);
		mask = 16'(rand_bits(16)) | 16'h0001;
		send(1'b1, SEL_W'(16'h0003), rstc_addr(), DATA_W'(mask));
		idle(1);
		high = 0;
		repeat (RST_PULSE + 8) begin
			@(negedge node_clk);
			if (periph_rst != 16'h0000) begin
				check_rst(periph_rst, m_mask);
				high++;
			end
		end
		if (high != RST_PULSE) begin
			$display("reset pulse lasted %0d cycles, expected %0d", high, RST_PULSE);
			errors++;
		end
		// clock enables then read back
		val = 3'(rand_bits(3));
		if (val == m_clken)
			val = ~val;
		send(1'b1, SEL_W'(16'h0004), rstc_addr(), DATA_W'(val) << 16);
		idle(1);
		@(negedge node_clk);
		check_clken(clken, m_clken);
		send(1'b0, '1, rstc_addr(), '0);
		drain();
		finish_test("reset control");
	endtask

	task automatic test_timer();
		int   rise [$];
		int   fall [$];
		logic prev;
		int   j;
		start_test();
		@(negedge node_clk);
		prev = tmr_irq;
		repeat (2 * TICK_PERIOD + TICK_OFF) begin
			@(negedge node_clk);
			if (tmr_irq && !prev)
				rise.push_back(cyc);
			if (!tmr_irq && prev)
				fall.push_back(cyc);
			prev = tmr_irq;
		end
		if (rise.size() < 2) begin
			$display("tmr_irq_o rose %0d times, expected at least 2", rise.size());
			errors++;
		end
		j = 0;
		for (int i = 0; i < rise.size(); i++) begin
			if (i > 0 && rise[i] - rise[i-1] != TICK_PERIOD) begin
				$display("tmr_irq_o period was %0d cycles, expected %0d",
					rise[i] - rise[i-1], TICK_PERIOD);
				errors++;
			end
			// first fall after this rise
			while (j < fall.size() && fall[j] < rise[i])
				j++;
			if (j < fall.size() && fall[j] - rise[i] != TICK_OFF - TICK_ON) begin
				$display("tmr_irq_o stayed high %0d cycles, expected %0d",
					fall[j] - rise[i], TICK_OFF - TICK_ON);
				errors++;
			end
		end
		finish_test("tick timer");
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		rst = 1'b1;
		req = '0;
		repeat (8) @(posedge node_clk);
		rst <= 1'b0;
		@(negedge node_clk);
		clken_at_rst = clken;
		prst_at_rst  = periph_rst;
		model_reset();
		test_scratch();
		test_led();
		test_unmapped();
		test_mixed();
		test_reset_ctrl();
		test_timer();
		$display("%0d tests, %0d with errors, %0d checks, %0d errors",
			n_tests, n_bad, n_checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+tb
rtl/bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/addr_router.sv
rtl/scratch_ram.sv
rtl/led_port.sv
rtl/reset_ctrl.sv
rtl/tick_timer.sv
rtl/resp_merge.sv
rtl/soc_fabric_top.sv
tb/soc_fabric_tb.sv

//--- Makefile
TOP := soc_fabric_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f all.f --top-module $(TOP)

# the log decides, not the exit code of the model
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f all.f --top-module soc_fabric_top

clean:
	rm -rf obj_dir sim.log
